// File: lsu_top.f
+incdir+.
lsu_pkg.sv
ls_queue.sv
mem_access.sv
data_ram.sv
load_align.sv
lsu_top.sv
lsu_checker.sv
tb_lsu_top.sv

// File: tb_lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int TEST_CYCLES = 4000;

    logic    clk_in;
    logic    arst_n;
    logic    ls_valid;
    logic    ls_is_store;
    ls_op_t  ls_op;
    rob_id_t ls_rob_id;
    logic    ls_full;
    logic    opnd_valid;
    rob_id_t opnd_rob_id;
    word_t   opnd_addr;
    word_t   opnd_data;
    logic    commit_valid;
    rob_id_t commit_rob_id;
    logic    flush;
    cdb_t    cdb;
    int      pending;
    int      errors;
    rob_id_t next_id;
    int      tests_run;
    int      tests_failed;

    lsu_top uut (
        .clk_in(clk_in), .arst_n(arst_n), .ls_valid(ls_valid), .ls_is_store(ls_is_store),
        .ls_op(ls_op), .ls_rob_id(ls_rob_id), .ls_full(ls_full), .opnd_valid(opnd_valid),
        .opnd_rob_id(opnd_rob_id), .opnd_addr(opnd_addr), .opnd_data(opnd_data),
        .commit_valid(commit_valid), .commit_rob_id(commit_rob_id), .flush(flush), .cdb(cdb)
    );

    lsu_checker u_chk (
        .clk_in(clk_in), .arst_n(arst_n), .ls_valid(ls_valid), .ls_is_store(ls_is_store),
        .ls_op(ls_op), .ls_rob_id(ls_rob_id), .ls_full(ls_full), .opnd_valid(opnd_valid),
        .opnd_rob_id(opnd_rob_id), .opnd_addr(opnd_addr), .opnd_data(opnd_data),
        .commit_valid(commit_valid), .commit_rob_id(commit_rob_id), .flush(flush), .cdb(cdb),
        .pending(pending), .errors(errors)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial begin
        #(TEST_CYCLES * 8 + 2000);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $finish;
    endtask

    function automatic ls_op_t rand_op();
        ls_op_t ops [5] = '{LS_OP_B, LS_OP_H, LS_OP_W, LS_OP_BU, LS_OP_HU};
        return ops[$urandom % 5];
    endfunction

    // aligned to the access size and below 1 KiB
    function automatic word_t rand_addr(ls_op_t op);
        word_t a;
        a = $urandom % 1024;
        if (op[1:0] == 2'b01) a[0] = 1'b0;
        if (op[1:0] == 2'b10) a[1:0] = 2'b00;
        return a;
    endfunction

    // every strobe task starts and ends on a falling edge
    task automatic dispatch(input logic st, input ls_op_t op, output rob_id_t id);
        while (ls_full) @(negedge clk_in);
        ls_valid    = 1'b1;
        ls_is_store = st;
        ls_op       = op;
        ls_rob_id   = next_id;
        id          = next_id;
        next_id     = next_id + 1'b1;
        @(negedge clk_in);
        ls_valid = 1'b0;
    endtask

    task automatic send_opnd(rob_id_t id, word_t addr, word_t data);
        opnd_valid  = 1'b1;
        opnd_rob_id = id;
        opnd_addr   = addr;
        opnd_data   = data;
        @(negedge clk_in);
        opnd_valid = 1'b0;
    endtask

    task automatic send_commit(rob_id_t id);
        commit_valid  = 1'b1;
        commit_rob_id = id;
        @(negedge clk_in);
        commit_valid = 1'b0;
    endtask

    task automatic issue_op(logic st, ls_op_t op, word_t addr, word_t data);
        rob_id_t id;
        dispatch(st, op, id);
        send_opnd(id, addr, data);
        if (st) send_commit(id);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending != 0) begin
            @(negedge clk_in);
            n++;
            if (n > 500) abort_run("outstanding operations never completed");
        end
        repeat (6) @(negedge clk_in);
    endtask

    task automatic finish_test(string name, int errs_before);
        wait_drain();
        tests_run++;
        if (errors != errs_before) tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    endtask

    task automatic test_lanes();
        word_t a;
        for (int r = 0; r < 4; r++) begin
            a = rand_addr(LS_OP_W);
            issue_op(1'b1, LS_OP_W, a, $urandom);
            for (int off = 0; off < 4; off++) begin
                issue_op(1'b0, LS_OP_B, a + off, $urandom);
                issue_op(1'b0, LS_OP_BU, a + off, $urandom);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_op(1'b0, LS_OP_H, a + off, $urandom);
                issue_op(1'b0, LS_OP_HU, a + off, $urandom);
            end
        end
    endtask

    task automatic test_order();
        rob_id_t ids [6];
        logic    st  [6];
        ls_op_t  ops [6];
        int      perm [6];
        int      j;
        int      t;
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 6; i++) begin
                st[i]   = $urandom % 2;
                ops[i]  = rand_op();
                perm[i] = i;
                dispatch(st[i], ops[i], ids[i]);
            end
            for (int i = 5; i > 0; i--) begin
                j       = $urandom % (i + 1);
                t       = perm[i];
                perm[i] = perm[j];
                perm[j] = t;
            end
            for (int i = 0; i < 6; i++) begin
                send_opnd(ids[perm[i]], rand_addr(ops[perm[i]]), $urandom);
                // some commits arrive ahead of operands
                if (st[perm[5 - i]]) send_commit(ids[perm[5 - i]]);
            end
        end
    endtask

    task automatic test_commit();
        rob_id_t id;
        for (int r = 0; r < 3; r++) begin
            dispatch(1'b1, LS_OP_W, id);
            send_opnd(id, rand_addr(LS_OP_W), $urandom);
            repeat (10) @(negedge clk_in);
            send_commit(id);
            wait_drain();
        end
    endtask

    task automatic test_forward();
        rob_id_t s_id;
        rob_id_t l_id;
        ls_op_t  op;
        word_t   a;
        for (int r = 0; r < 8; r++) begin
            op = rand_op();
            a  = rand_addr(op);
            dispatch(1'b1, op, s_id);
            dispatch(1'b0, LS_OP_W, l_id);
            send_opnd(l_id, {a[31:2], 2'b00}, $urandom);
            send_opnd(s_id, a, $urandom);
            send_commit(s_id);
        end
    endtask

    task automatic test_full();
        rob_id_t ids [31];
        for (int i = 0; i < 31; i++) dispatch(1'b0, rand_op(), ids[i]);
        repeat (3) @(negedge clk_in);
        if (!ls_full) abort_run("ls_full did not rise with 31 blocked entries");
        for (int i = 0; i < 31; i++) send_opnd(ids[i], rand_addr(LS_OP_W), $urandom);
    endtask

    task automatic test_flush();
        rob_id_t head_id;
        rob_id_t id;
        dispatch(1'b0, rand_op(), head_id);
        for (int i = 0; i < 2; i++) dispatch(1'b0, rand_op(), id);
        dispatch(1'b1, LS_OP_W, id);
        // head load is still in the pipeline when the flush lands
        send_opnd(head_id, rand_addr(LS_OP_W), $urandom);
        send_opnd(id, rand_addr(LS_OP_W), $urandom);
        flush = 1'b1;
        @(negedge clk_in);
        flush = 1'b0;
        repeat (10) @(negedge clk_in);
        for (int i = 0; i < 12; i++) begin
            issue_op($urandom % 2, LS_OP_W, rand_addr(LS_OP_W), $urandom);
        end
    endtask

    initial begin
        int e0;
        void'($urandom(32'h6f5009f8));
        arst_n        = 1'b0;
        ls_valid      = 1'b0;
        ls_is_store   = 1'b0;
        ls_op         = LS_OP_W;
        ls_rob_id     = '0;
        opnd_valid    = 1'b0;
        opnd_rob_id   = '0;
        opnd_addr     = '0;
        opnd_data     = '0;
        commit_valid  = 1'b0;
        commit_rob_id = '0;
        flush         = 1'b0;
        next_id       = '0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
        repeat (2) @(negedge clk_in);
        e0 = errors;
        test_lanes();
        finish_test("byte and halfword lanes", e0);
        e0 = errors;
        test_order();
        finish_test("dispatch order", e0);
        e0 = errors;
        test_commit();
        finish_test("store commit latency", e0);
        e0 = errors;
        test_forward();
        finish_test("load behind store", e0);
        e0 = errors;
        test_full();
        finish_test("queue full level", e0);
        e0 = errors;
        test_flush();
        finish_test("flush", e0);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_checker (
    input  logic             clk_in,
    input  logic             arst_n,
    input  logic             ls_valid,
    input  logic             ls_is_store,
    input  lsu_pkg::ls_op_t  ls_op,
    input  lsu_pkg::rob_id_t ls_rob_id,
    input  logic             ls_full,
    input  logic             opnd_valid,
    input  lsu_pkg::rob_id_t opnd_rob_id,
    input  lsu_pkg::word_t   opnd_addr,
    input  lsu_pkg::word_t   opnd_data,
    input  logic             commit_valid,
    input  lsu_pkg::rob_id_t commit_rob_id,
    input  logic             flush,
    input  lsu_pkg::cdb_t    cdb,
    output int               pending,
    output int               errors
);
    import lsu_pkg::*;

    localparam int IDS = 1 << `LSU_ROB_W;
    // commit edge to the edge that raises cdb valid
    localparam int COMMIT_TO_CDB = 4;

    logic    e_store  [IDS];
    ls_op_t  e_op     [IDS];
    word_t   e_addr   [IDS];
    word_t   e_data   [IDS];
    logic    e_opnd   [IDS];
    logic    e_commit [IDS];
    logic    e_exact  [IDS];
    int      e_ccyc   [IDS];
    rob_id_t order    [$];
    word_t   mem_model [256];
    int      cyc;

    function automatic int size_bytes(ls_op_t op);
        case (op[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    // little endian lanes, sign fill unless op bit 2 asks for zero
    function automatic word_t expected_value(ls_op_t op, logic st, word_t addr, word_t w);
        logic [7:0] b [4];
        word_t      v;
        int         n;
        if (st) return '0;
        for (int k = 0; k < 4; k++) b[k] = w[8*k +: 8];
        n = size_bytes(op);
        v = '0;
        for (int k = 0; k < n; k++) v[8*k +: 8] = b[addr[1:0] + k];
        if (!op[2] && n < 4 && v[8*n-1]) begin
            for (int k = n; k < 4; k++) v[8*k +: 8] = 8'hff;
        end
        return v;
    endfunction

    function automatic word_t store_merge(ls_op_t op, word_t addr, word_t data, word_t w);
        for (int k = 0; k < size_bytes(op); k++) w[8*(addr[1:0] + k) +: 8] = data[8*k +: 8];
        return w;
    endfunction

    // entries from the first blocked one onward cannot have left the DUT queue
    function automatic int stuck_count();
        for (int i = 0; i < order.size(); i++) begin
            if (!e_opnd[order[i]] || (e_store[order[i]] && !e_commit[order[i]])) begin
                return order.size() - i;
            end
        end
        return 0;
    endfunction

    task automatic value_error(string sig, word_t got, word_t exp);
        $display("Error: %s got %h expected %h", sig, got, exp);
        errors++;
    endtask

    task automatic plain_error(string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_cdb();
        rob_id_t id;
        word_t   exp;
        if (order.size() == 0) begin
            plain_error($sformatf("broadcast for id %0d with nothing outstanding", cdb.rob_id));
            return;
        end
        id = order.pop_front();
        if (cdb.rob_id != id) value_error("cdb.rob_id", word_t'(cdb.rob_id), word_t'(id));
        exp = expected_value(e_op[id], e_store[id], e_addr[id], mem_model[e_addr[id][9:2]]);
        if (cdb.value != exp) value_error("cdb.value", cdb.value, exp);
        if (e_store[id]) begin
            if (!e_commit[id]) plain_error($sformatf("store %0d completed before commit", id));
            // sampled one edge after cdb valid rises
            if (e_exact[id] && (cyc - e_ccyc[id] != COMMIT_TO_CDB + 1)) begin
                plain_error($sformatf("store %0d completed %0d cycles after commit",
                                      id, cyc - e_ccyc[id] - 1));
            end
            mem_model[e_addr[id][9:2]] = store_merge(e_op[id], e_addr[id], e_data[id],
                                                     mem_model[e_addr[id][9:2]]);
        end
    endtask

    initial begin
        errors  = 0;
        pending = 0;
        for (int i = 0; i < 256; i++) mem_model[i] = '0;
    end

    always @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            order.delete();
            cyc = 0;
        end else begin
            cyc++;
            if (stuck_count() >= `LSU_QDEPTH - 1 && !ls_full) begin
                plain_error($sformatf("ls_full low with %0d blocked entries", stuck_count()));
            end
            if (order.size() < `LSU_QDEPTH - 1 && ls_full) begin
                plain_error($sformatf("ls_full high with %0d outstanding", order.size()));
            end
            if (ls_valid && ls_full) plain_error("dispatch seen while ls_full high");
            if (cdb.valid) check_cdb();
            if (flush) begin
                order.delete();
            end else begin
                if (ls_valid) begin
                    e_store[ls_rob_id]  = ls_is_store;
                    e_op[ls_rob_id]     = ls_op;
                    e_opnd[ls_rob_id]   = 1'b0;
                    e_commit[ls_rob_id] = 1'b0;
                    e_exact[ls_rob_id]  = 1'b0;
                    order.push_back(ls_rob_id);
                end
                if (opnd_valid) begin
                    e_addr[opnd_rob_id] = opnd_addr;
                    e_data[opnd_rob_id] = opnd_data;
                    e_opnd[opnd_rob_id] = 1'b1;
                end
                if (commit_valid) begin
                    e_commit[commit_rob_id] = 1'b1;
                    // alone and ready, so latency is fixed
                    if (e_opnd[commit_rob_id] && order.size() == 1 &&
                        order[0] == commit_rob_id) begin
                        e_exact[commit_rob_id] = 1'b1;
                        e_ccyc[commit_rob_id]  = cyc;
                    end
                end
            end
            pending = order.size();
        end
    end

endmodule

`default_nettype wire

// File: lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module lsu_top (
    input  logic             clk_in,
    input  logic             arst_n,
    input  logic             ls_valid,
    input  logic             ls_is_store,
    input  lsu_pkg::ls_op_t  ls_op,
    input  lsu_pkg::rob_id_t ls_rob_id,
    output logic             ls_full,
    input  logic             opnd_valid,
    input  lsu_pkg::rob_id_t opnd_rob_id,
    input  lsu_pkg::word_t   opnd_addr,
    input  lsu_pkg::word_t   opnd_data,
    input  logic             commit_valid,
    input  lsu_pkg::rob_id_t commit_rob_id,
    input  logic             flush,
    output lsu_pkg::cdb_t    cdb
);
    import lsu_pkg::*;

    mem_req_t               mem_req;
    logic [`LSU_RAM_AW-1:0] ram_addr;
    logic                   ram_we;
    logic [3:0]             ram_be;
    word_t                  ram_wdata;
    word_t                  ram_rdata;
    ld_meta_t               meta;

    ls_queue u_queue (
        .clk_in        (clk_in),
        .arst_n        (arst_n),
        .ls_valid      (ls_valid),
        .ls_is_store   (ls_is_store),
        .ls_op         (ls_op),
        .ls_rob_id     (ls_rob_id),
        .opnd_valid    (opnd_valid),
        .opnd_rob_id   (opnd_rob_id),
        .opnd_addr     (opnd_addr),
        .opnd_data     (opnd_data),
        .commit_valid  (commit_valid),
        .commit_rob_id (commit_rob_id),
        .flush         (flush),
        .ls_full       (ls_full),
        .mem_req       (mem_req)
    );

    mem_access u_access (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .flush     (flush),
        .mem_req   (mem_req),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata),
        .meta      (meta)
    );

    data_ram u_ram (
        .clk_in (clk_in),
        .addr   (ram_addr),
        .we     (ram_we),
        .be     (ram_be),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

    load_align u_align (
        .clk_in (clk_in),
        .arst_n (arst_n),
        .flush  (flush),
        .meta   (meta),
        .rdata  (ram_rdata),
        .cdb    (cdb)
    );

endmodule

`default_nettype wire

// File: load_align.sv
`timescale 1ns/10ps
`default_nettype none

module load_align (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              flush,
    input  lsu_pkg::ld_meta_t meta,
    input  lsu_pkg::word_t    rdata,
    output lsu_pkg::cdb_t     cdb
);
    import lsu_pkg::*;

    word_t lane;
    word_t value;

    // addressed byte or halfword moved down to bit 0
    assign lane = rdata >> {meta.offset, 3'b000};

    always_comb begin
        case (meta.op)
            LS_OP_B:  value = {{24{lane[7]}}, lane[7:0]};
            LS_OP_H:  value = {{16{lane[15]}}, lane[15:0]};
            LS_OP_BU: value = {24'h0, lane[7:0]};
            LS_OP_HU: value = {16'h0, lane[15:0]};
            default:  value = rdata;
        endcase
        // stores report zero
        if (meta.is_store) value = '0;
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            cdb <= '0;
        end else begin
            cdb.valid  <= meta.valid && !flush;
            cdb.rob_id <= meta.rob_id;
            cdb.value  <= value;
        end
    end

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module data_ram (
    input  logic                   clk_in,
    input  logic [`LSU_RAM_AW-1:0] addr,
    input  logic                   we,
    input  logic [3:0]             be,
    input  lsu_pkg::word_t         wdata,
    output lsu_pkg::word_t         rdata
);
    import lsu_pkg::*;

    localparam int WORDS = 1 << `LSU_RAM_AW;

    word_t mem [WORDS];

    initial begin
        for (int i = 0; i < WORDS; i++) mem[i] = '0;
    end

    always @(posedge clk_in) begin
        for (int b = 0; b < 4; b++) begin
            if (we && be[b]) begin
                mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                // new byte goes straight to the read port
                rdata[8*b +: 8]     <= wdata[8*b +: 8];
            end else begin
                rdata[8*b +: 8]     <= mem[addr][8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_access.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module mem_access (
    input  logic                   clk_in,
    input  logic                   arst_n,
    input  logic                   flush,
    input  lsu_pkg::mem_req_t      mem_req,
    output logic [`LSU_RAM_AW-1:0] ram_addr,
    output logic                   ram_we,
    output logic [3:0]             ram_be,
    output lsu_pkg::word_t         ram_wdata,
    output lsu_pkg::ld_meta_t      meta
);
    import lsu_pkg::*;

    mem_req_t   req_q;
    logic [3:0] lane_mask;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= '0;
        end else begin
            req_q       <= mem_req;
            req_q.valid <= mem_req.valid && !flush;
        end
    end

    // byte lanes touched by this access
    always_comb begin
        case (req_q.op[1:0])
            2'b00:   lane_mask = 4'b0001 << req_q.addr[1:0];
            2'b01:   lane_mask = 4'b0011 << req_q.addr[1:0];
            default: lane_mask = 4'b1111;
        endcase
    end

    assign ram_addr  = req_q.addr[`LSU_RAM_AW+1:2];
    assign ram_we    = req_q.valid && req_q.is_store;
    assign ram_be    = lane_mask;
    assign ram_wdata = req_q.data << {req_q.addr[1:0], 3'b000};

    // metadata lines up with the registered RAM read
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            meta <= '0;
        end else begin
            meta.valid    <= req_q.valid && !flush;
            meta.is_store <= req_q.is_store;
            meta.op       <= req_q.op;
            meta.offset   <= req_q.addr[1:0];
            meta.rob_id   <= req_q.rob_id;
        end
    end

    a_aligned: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        req_q.valid && (req_q.op[1:0] != 2'b00) |->
            !req_q.addr[0] && ((req_q.op[1:0] == 2'b01) || !req_q.addr[1])
    ) else $error("misaligned access at %h", req_q.addr);

endmodule

`default_nettype wire

// File: ls_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_params.svh"

module ls_queue (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              ls_valid,
    input  logic              ls_is_store,
    input  lsu_pkg::ls_op_t   ls_op,
    input  lsu_pkg::rob_id_t  ls_rob_id,
    input  logic              opnd_valid,
    input  lsu_pkg::rob_id_t  opnd_rob_id,
    input  lsu_pkg::word_t    opnd_addr,
    input  lsu_pkg::word_t    opnd_data,
    input  logic              commit_valid,
    input  lsu_pkg::rob_id_t  commit_rob_id,
    input  logic              flush,
    output logic              ls_full,
    output lsu_pkg::mem_req_t mem_req
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_QDEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    ls_state_t state_q    [DEPTH];
    logic      is_store_q [DEPTH];
    ls_op_t    op_q       [DEPTH];
    rob_id_t   rob_id_q   [DEPTH];
    word_t     addr_q     [DEPTH];
    word_t     data_q     [DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;
    logic [DEPTH-1:0] opnd_hit;
    logic [DEPTH-1:0] commit_hit;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // keep only the bytes the store will write
    function automatic word_t trunc_store(ls_op_t op, word_t data);
        case (op[1:0])
            2'b00:   return {24'h0, data[7:0]};
            2'b01:   return {16'h0, data[15:0]};
            default: return data;
        endcase
    endfunction

    // a commit may land before the operands, COMMITTED remembers it
    function automatic ls_state_t next_state(ls_state_t st, logic is_st,
                                             logic got_opnd, logic got_commit);
        ls_state_t nxt;
        nxt = st;
        case (st)
            ST_WAIT_OPND: begin
                if (got_opnd && (!is_st || got_commit)) nxt = ST_READY;
                else if (got_opnd) nxt = ST_WAIT_COMMIT;
                else if (got_commit) nxt = ST_COMMITTED;
            end
            ST_WAIT_COMMIT: if (got_commit) nxt = ST_READY;
            ST_COMMITTED:   if (got_opnd) nxt = ST_READY;
            default:        nxt = st;
        endcase
        return nxt;
    endfunction

    // associative match against busy entries
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            opnd_hit[i]   = opnd_valid && (state_q[i] != ST_EMPTY) &&
                            (rob_id_q[i] == opnd_rob_id);
            commit_hit[i] = commit_valid && (state_q[i] != ST_EMPTY) && is_store_q[i] &&
                            (rob_id_q[i] == commit_rob_id);
        end
    end

    assign pop     = (state_q[head_q] == ST_READY) && !flush;
    assign ls_full = count_q >= (PTR_W + 1)'(DEPTH - 1);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) state_q[i] <= ST_EMPTY;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            for (int i = 0; i < DEPTH; i++) state_q[i] <= ST_EMPTY;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                state_q[i] <= next_state(state_q[i], is_store_q[i], opnd_hit[i], commit_hit[i]);
            end
            if (pop) begin
                state_q[head_q] <= ST_EMPTY;
                head_q          <= ptr_inc(head_q);
            end
            if (ls_valid) begin
                state_q[tail_q] <= ST_WAIT_OPND;
                tail_q          <= ptr_inc(tail_q);
            end
            if (ls_valid && !pop) count_q <= count_q + 1'b1;
            else if (!ls_valid && pop) count_q <= count_q - 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clk_in) begin
        if (ls_valid) begin
            is_store_q[tail_q] <= ls_is_store;
            op_q[tail_q]       <= ls_op;
            rob_id_q[tail_q]   <= ls_rob_id;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (opnd_hit[i]) begin
                addr_q[i] <= opnd_addr;
                data_q[i] <= trunc_store(op_q[i], opnd_data);
            end
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            mem_req <= '0;
        end else begin
            mem_req.valid    <= pop;
            mem_req.is_store <= is_store_q[head_q];
            mem_req.op       <= op_q[head_q];
            mem_req.rob_id   <= rob_id_q[head_q];
            mem_req.addr     <= addr_q[head_q];
            mem_req.data     <= data_q[head_q];
        end
    end

    a_no_dispatch_full: assert property (
        @(posedge clk_in) disable iff (!arst_n) ls_valid |-> !ls_full
    ) else $error("dispatch while ls_full");

    // the id must already sit in the queue when its operands arrive
    a_opnd_hits_busy: assert property (
        @(posedge clk_in) disable iff (!arst_n) opnd_valid && !flush |-> $onehot(opnd_hit)
    ) else $error("operand strobe for id %0d hit no busy entry", opnd_rob_id);

endmodule

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_ROB_W-1:0] rob_id_t;
    typedef logic [31:0]           word_t;
    // funct3 size code of a load or store
    typedef logic [2:0]            ls_op_t;

    localparam ls_op_t LS_OP_B  = 3'd0;
    localparam ls_op_t LS_OP_H  = 3'd1;
    localparam ls_op_t LS_OP_W  = 3'd2;
    localparam ls_op_t LS_OP_BU = 3'd4;
    localparam ls_op_t LS_OP_HU = 3'd5;

    // request issued from the queue head
    typedef struct packed {
        logic    valid;
        logic    is_store;
        ls_op_t  op;
        rob_id_t rob_id;
        word_t   addr;
        word_t   data;
    } mem_req_t;

    // travels beside the RAM read
    typedef struct packed {
        logic       valid;
        logic       is_store;
        ls_op_t     op;
        logic [1:0] offset;
        rob_id_t    rob_id;
    } ld_meta_t;

    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   value;
    } cdb_t;

    typedef enum logic [2:0] {
        ST_EMPTY,
        ST_WAIT_OPND,
        ST_READY,
        ST_WAIT_COMMIT,
        ST_COMMITTED
    } ls_state_t;

endpackage

`default_nettype wire

// File: lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// queue entries, full is flagged one entry early
`define LSU_QDEPTH 32

// reorder-buffer id width
`define LSU_ROB_W 5

// data RAM word-address width, 256 words
`define LSU_RAM_AW 8

`endif
